//--- hdl/pico_l15_pkg.sv
package pico_l15_pkg;

    // core side widths
    typedef logic [31:0] pico_addr_t;
    typedef logic [31:0] pico_data_t;
    typedef logic [3:0]  pico_strb_t;

    // cache side widths
    // physical address is the core address zero-extended
    typedef logic [39:0] phy_addr_t;
    // cache data is big-endian, byte 0 of the line sits in [63:56]
    typedef logic [63:0] l15_data_t;
    typedef logic [4:0]  l15_rqtype_t;
    typedef logic [2:0]  l15_size_t;
    typedef logic [3:0]  l15_rettype_t;

    // request types
    localparam l15_rqtype_t RQ_LOAD  = 5'd0;
    localparam l15_rqtype_t RQ_STORE = 5'd1;

    // request sizes
    localparam l15_size_t SIZE_1B = 3'd0;
    localparam l15_size_t SIZE_2B = 3'd1;
    localparam l15_size_t SIZE_4B = 3'd2;

    // return types
    localparam l15_rettype_t RET_LOAD   = 4'd0;
    localparam l15_rettype_t RET_ST_ACK = 4'd4;
    localparam l15_rettype_t RET_INT    = 4'd7;

    // address bit that marks an uncached access
    localparam int NC_BIT = 31;

    // decoder issue machine
    typedef enum logic [1:0] {
        DEC_IDLE,
        DEC_SEND,
        DEC_WAIT
    } dec_state_t;

    // single-flit request toward the cache, 113 bits
    typedef struct packed {
        l15_rqtype_t rqtype;
        l15_size_t   size;
        phy_addr_t   address;
        l15_data_t   data;
        logic        nc;
    } l15_req_t;

    // return from the cache, 68 bits
    typedef struct packed {
        l15_rettype_t returntype;
        l15_data_t    data_0;
    } l15_ret_t;

    // swap byte order of a 32-bit word
    // used on both paths, little-endian core vs big-endian cache
    function automatic pico_data_t bswap32(input pico_data_t w);
        return {w[7:0], w[15:8], w[23:16], w[31:24]};
    endfunction

endpackage

//--- hdl/pico_decoder.sv
module pico_decoder (
    input  logic                     clk,
    input  logic                     rst_n,

    // core memory port
    input  logic                     mem_valid,
    input  pico_l15_pkg::pico_addr_t mem_addr,
    input  pico_l15_pkg::pico_strb_t mem_wstrb,
    input  pico_l15_pkg::pico_data_t mem_wdata,

    // request toward the cache
    input  logic                     l15_ack,
    output logic                     l15_val,
    output pico_l15_pkg::l15_req_t   req
);

    import pico_l15_pkg::*;

    dec_state_t state;
    dec_state_t state_nxt;

    // request built from the live core signals
    l15_req_t   req_nxt;
    // byte offset inside the word, taken from the strobe lane
    logic [1:0] lane_ofs;
    pico_data_t wdata_be;

    // strobe pattern decides type, size and lane
    always_comb begin
        lane_ofs = 2'd0;
        req_nxt.rqtype = RQ_STORE;
        req_nxt.size = SIZE_4B;
        case (mem_wstrb)
            4'b0000: begin
                // no strobe means a load, always a full word
                req_nxt.rqtype = RQ_LOAD;
            end
            4'b0001: begin
                req_nxt.size = SIZE_1B;
            end
            4'b0010: begin
                req_nxt.size = SIZE_1B;
                lane_ofs = 2'd1;
            end
            4'b0100: begin
                req_nxt.size = SIZE_1B;
                lane_ofs = 2'd2;
            end
            4'b1000: begin
                req_nxt.size = SIZE_1B;
                lane_ofs = 2'd3;
            end
            4'b0011: begin
                req_nxt.size = SIZE_2B;
            end
            4'b1100: begin
                req_nxt.size = SIZE_2B;
                lane_ofs = 2'd2;
            end
            default: begin
                // full word store, other patterns are not issued by the core
                req_nxt.size = SIZE_4B;
            end
        endcase

        // word base plus lane gives an address aligned to the size
        req_nxt.address = {8'd0, mem_addr[31:2], lane_ofs};

        // big-endian word copied to both halves
        // the cache picks the half by address bit 2
        wdata_be = bswap32(mem_wdata);
        req_nxt.data = {wdata_be, wdata_be};

        req_nxt.nc = mem_addr[NC_BIT];
    end

    // issue machine
    always_comb begin
        state_nxt = state;
        case (state)
            DEC_IDLE: begin
                if (mem_valid) begin
                    state_nxt = DEC_SEND;
                end
            end
            DEC_SEND: begin
                // hold val and req until the cache takes it
                if (l15_ack) begin
                    state_nxt = DEC_WAIT;
                end
            end
            DEC_WAIT: begin
                // one request per core access
                if (!mem_valid) begin
                    state_nxt = DEC_IDLE;
                end
            end
            default: begin
                state_nxt = DEC_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= DEC_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // capture only when leaving idle, so req stays stable while waiting
    always_ff @(posedge clk) begin
        if (state == DEC_IDLE && mem_valid) begin
            req <= req_nxt;
        end
    end

    // val straight from the state register
    assign l15_val = (state == DEC_SEND);

endmodule

//--- hdl/l15_picoencoder.sv
module l15_picoencoder (
    input  logic                      clk,
    input  logic                      rst_n,

    // return from the cache
    input  logic                      ret_val,
    input  pico_l15_pkg::l15_ret_t    ret,

    // address of the request in flight, from the decoder
    input  pico_l15_pkg::phy_addr_t   req_address,

    // core response
    output logic                      mem_ready,
    output pico_l15_pkg::pico_data_t  mem_rdata,

    output logic                      l15_req_ack,
    output logic                      pico_int
);

    import pico_l15_pkg::*;

    // return type decode
    logic is_load;
    logic is_st_ack;
    logic is_int;

    // addressed word of the 64-bit return, still big-endian
    pico_data_t word_be;
    // same word in core byte order
    pico_data_t word_le;

    assign is_load   = ret_val && (ret.returntype == RET_LOAD);
    assign is_st_ack = ret_val && (ret.returntype == RET_ST_ACK);
    assign is_int    = ret_val && (ret.returntype == RET_INT);

    // bit 2 clear selects the upper half, lower addresses come first
    always_comb begin
        if (req_address[2]) begin
            word_be = ret.data_0[31:0];
        end else begin
            word_be = ret.data_0[63:32];
        end
        word_le = bswap32(word_be);
    end

    // every return is taken in its own cycle
    assign l15_req_ack = ret_val;

    // ready and interrupt are one-cycle pulses
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mem_ready <= 1'b0;
            pico_int  <= 1'b0;
        end else begin
            mem_ready <= is_load || is_st_ack;
            // interrupt return never completes a core access
            pico_int  <= is_int;
        end
    end

    // read data for the core
    // store ack returns zero, interrupt leaves it untouched
    always_ff @(posedge clk) begin
        if (is_load) begin
            mem_rdata <= word_le;
        end else if (is_st_ack) begin
            mem_rdata <= '0;
        end
    end

endmodule

//--- hdl/pico_l15_transducer.sv
module pico_l15_transducer (
    input  logic                     clk,
    input  logic                     rst_n,

    // core to cache
    input  logic                     mem_valid,
    input  pico_l15_pkg::pico_addr_t mem_addr,
    input  pico_l15_pkg::pico_strb_t mem_wstrb,
    input  pico_l15_pkg::pico_data_t mem_wdata,

    // request channel
    output logic                     l15_val,
    output pico_l15_pkg::l15_req_t   req,
    input  logic                     l15_ack,

    // return channel
    input  logic                     ret_val,
    input  pico_l15_pkg::l15_ret_t   ret,
    output logic                     l15_req_ack,

    // cache to core
    output logic                     mem_ready,
    output pico_l15_pkg::pico_data_t mem_rdata,
    output logic                     pico_int
);

    // request path
    pico_decoder i_pico_decoder (
        .clk       (clk),
        .rst_n     (rst_n),
        .mem_valid (mem_valid),
        .mem_addr  (mem_addr),
        .mem_wstrb (mem_wstrb),
        .mem_wdata (mem_wdata),
        .l15_ack   (l15_ack),
        .l15_val   (l15_val),
        .req       (req)
    );

    // return path, word select follows the request in flight
    l15_picoencoder i_l15_picoencoder (
        .clk         (clk),
        .rst_n       (rst_n),
        .ret_val     (ret_val),
        .ret         (ret),
        .req_address (req.address),
        .mem_ready   (mem_ready),
        .mem_rdata   (mem_rdata),
        .l15_req_ack (l15_req_ack),
        .pico_int    (pico_int)
    );

endmodule

//--- tb/l15_model.sv
module l15_model (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     l15_val,
    input  pico_l15_pkg::l15_req_t   req,
    output logic                     l15_ack,
    output logic                     ret_val,
    output pico_l15_pkg::l15_ret_t   ret,
    input  logic                     l15_req_ack,
    // core access in flight, source of the expected request
    input  pico_l15_pkg::pico_addr_t mem_addr,
    input  pico_l15_pkg::pico_strb_t mem_wstrb,
    input  pico_l15_pkg::pico_data_t mem_wdata,
    input  logic                     int_cmd,
    output int                       err_count,
    output int                       accept_count
);

    import pico_l15_pkg::*;

    // big-endian lines by address bits 39 to 3
    l15_data_t mem [logic [36:0]];
    integer    seed;
    l15_req_t  held;
    l15_data_t line;

    // req must not move while ack is withheld
    task automatic check_held();
        if (l15_val !== 1'b1 || req !== held) begin
            err_count++;
            $display("Mismatch req while ack held back: l15_val %h req %h expected %h",
                     l15_val, req, held);
        end
    endtask

    // predict the request from the core access, then write or read the line
    task automatic accept_request();
        pico_data_t  be;
        phy_addr_t   exp_addr;
        l15_rqtype_t exp_type;
        l15_size_t   exp_size;
        int          cnt;
        int          low;
        int          off;
        int          i;
        int          p;
        accept_count++;
        cnt = 0;
        low = 0;
        for (i = 3; i >= 0; i--) begin
            if (mem_wstrb[i]) begin
                cnt++;
                low = i;
            end
            // core byte i sits at big-endian byte i of the word
            be[31-8*i -: 8] = mem_wdata[8*i +: 8];
        end
        exp_type = (cnt == 0) ? RQ_LOAD : RQ_STORE;
        exp_size = (cnt == 1) ? SIZE_1B : ((cnt == 2) ? SIZE_2B : SIZE_4B);
        // word address plus lowest strobe lane, aligned to the size
        exp_addr = {8'd0, mem_addr};
        exp_addr[1:0] = low[1:0];
        if (held.rqtype !== exp_type) begin
            err_count++;
            $display("Mismatch req.rqtype: got %h expected %h", held.rqtype, exp_type);
        end
        if (held.size !== exp_size) begin
            err_count++;
            $display("Mismatch req.size: got %h expected %h", held.size, exp_size);
        end
        if (held.address !== exp_addr) begin
            err_count++;
            $display("Mismatch req.address: got %h expected %h", held.address, exp_addr);
        end
        if (held.nc !== mem_addr[31]) begin
            err_count++;
            $display("Mismatch req.nc: got %h expected %h", held.nc, mem_addr[31]);
        end
        if (cnt != 0 && held.data !== {be, be}) begin
            err_count++;
            $display("Mismatch req.data: got %h expected %h", held.data, {be, be});
        end
        // unwritten lines read back a pattern of their own address
        line = mem.exists(held.address[39:3]) ? mem[held.address[39:3]]
                                               : {held.address[39:3], held.address[29:3]};
        if (cnt != 0) begin
            off = int'(held.address[2:0]);
            for (p = 0; p < 8; p++) begin
                if (p >= off && p < off + cnt) begin
                    line[63-8*p -: 8] = held.data[63-8*p -: 8];
                end
            end
            mem[held.address[39:3]] = line;
            // store ack carries no data
            line = '0;
        end
    endtask

    // one-cycle return, ack expected in the same cycle
    task automatic send_return(input l15_rettype_t t, input l15_data_t d);
        #1;
        ret_val = 1'b1;
        ret.returntype = t;
        ret.data_0 = d;
        @(posedge clk);
        if (l15_req_ack !== 1'b1) begin
            err_count++;
            $display("ERROR: return of type %0d was not acknowledged in its own cycle", t);
        end
        #1;
        ret_val = 1'b0;
        ret = '0;
    endtask

    initial begin
        seed = 32'hc315;
        err_count = 0;
        accept_count = 0;
        l15_ack = 1'b0;
        ret_val = 1'b0;
        ret = '0;
        forever begin
            @(posedge clk);
            if (rst_n && int_cmd && !l15_val) begin
                send_return(RET_INT, '0);
            end else if (rst_n && l15_val) begin
                held = req;
                repeat ($unsigned($random(seed)) % 4) begin
                    @(posedge clk);
                    check_held();
                end
                #1 l15_ack = 1'b1;
                // val and ack both high at this edge
                @(posedge clk);
                check_held();
                #1 l15_ack = 1'b0;
                accept_request();
                repeat (1 + $unsigned($random(seed)) % 4) @(posedge clk);
                send_return((held.rqtype == RQ_STORE) ? RET_ST_ACK : RET_LOAD, line);
            end
        end
    end

endmodule

//--- tb/tb_pico_l15_transducer.sv
module tb_pico_l15_transducer;

    import pico_l15_pkg::*;

    logic       clk;
    logic       rst_n;
    logic       mem_valid;
    pico_addr_t mem_addr;
    pico_strb_t mem_wstrb;
    pico_data_t mem_wdata;
    logic       mem_ready;
    pico_data_t mem_rdata;
    logic       l15_val;
    l15_req_t   req;
    logic       l15_ack;
    logic       ret_val;
    l15_ret_t   ret;
    logic       l15_req_ack;
    logic       pico_int;
    logic       int_cmd;

    integer     seed;
    int         stim_errs = 0;
    int         cmp_errs = 0;
    int         model_errs;
    int         accepts;
    int         accesses = 0;
    int         ready_pulses = 0;
    int         int_pulses = 0;
    // expected read data of the access in flight
    logic       pending;
    pico_data_t exp_rdata;
    // set when a wait runs out and the stimulus stops early
    logic       timed_out;
    // little-endian word memory by address bits 31 to 2
    pico_data_t ref_mem [logic [29:0]];

    pico_l15_transducer i_dut (.*);

    l15_model i_model (
        .clk          (clk),
        .rst_n        (rst_n),
        .l15_val      (l15_val),
        .req          (req),
        .l15_ack      (l15_ack),
        .ret_val      (ret_val),
        .ret          (ret),
        .l15_req_ack  (l15_req_ack),
        .mem_addr     (mem_addr),
        .mem_wstrb    (mem_wstrb),
        .mem_wdata    (mem_wdata),
        .int_cmd      (int_cmd),
        .err_count    (model_errs),
        .accept_count (accepts)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected rdata of one access, stores update the word memory and read back zero
    function automatic pico_data_t ref_access(input pico_addr_t a, input pico_strb_t s,
                                              input pico_data_t d);
        pico_data_t w;
        int         i;
        // every word is stored before it is loaded
        w = ref_mem.exists(a[31:2]) ? ref_mem[a[31:2]] : '0;
        if (s == 4'b0000) begin
            return w;
        end
        for (i = 0; i < 4; i++) begin
            if (s[i]) begin
                w[8*i +: 8] = d[8*i +: 8];
            end
        end
        ref_mem[a[31:2]] = w;
        return '0;
    endfunction

    // four cached words followed by four uncached ones with bit 31 set
    function automatic pico_addr_t pool_addr(input int k);
        return (k < 4) ? 32'h0000_0200 + pico_addr_t'(4 * k)
                       : 32'h8000_0300 + pico_addr_t'(4 * (k - 4));
    endfunction

    // loads plus the strobe patterns the core issues
    function automatic pico_strb_t pick_strobe(input int r);
        case (r)
            1: return 4'b0001;
            2: return 4'b0010;
            3: return 4'b0100;
            4: return 4'b1000;
            5: return 4'b0011;
            6: return 4'b1100;
            7: return 4'b1111;
            default: return 4'b0000;
        endcase
    endfunction

    task automatic finish_run();
        $display("errors: stimulus %0d, compare %0d, model %0d; accesses %0d, accepted %0d",
                 stim_errs, cmp_errs, model_errs, accesses, accepts);
        if (stim_errs + cmp_errs + model_errs == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    endtask

    // compare on every ready pulse
    always @(posedge clk) begin
        if (pico_int === 1'b1) begin
            int_pulses <= int_pulses + 1;
        end
        if (mem_ready === 1'b1) begin
            ready_pulses <= ready_pulses + 1;
            if (!pending) begin
                cmp_errs <= cmp_errs + 1;
                $display("ERROR: mem_ready pulsed with no core access in flight");
            end else if (mem_rdata !== exp_rdata) begin
                cmp_errs <= cmp_errs + 1;
                $display("Mismatch mem_rdata at %h: got %h expected %h",
                         mem_addr, mem_rdata, exp_rdata);
            end
        end
    end

    // one core access held until mem_ready and followed by one idle cycle
    task automatic core_access(input pico_addr_t a, input pico_strb_t s, input pico_data_t d);
        int waited;
        exp_rdata = ref_access(a, s, d);
        pending = 1'b1;
        accesses++;
        mem_valid = 1'b1;
        mem_addr = a;
        mem_wstrb = s;
        mem_wdata = d;
        waited = 0;
        @(posedge clk);
        while (mem_ready !== 1'b1 && waited < 50) begin
            waited++;
            @(posedge clk);
        end
        if (mem_ready !== 1'b1) begin
            stim_errs++;
            timed_out = 1'b1;
            $display("ERROR: no mem_ready within 50 cycles for access to %h", a);
        end else begin
            #1;
            mem_valid = 1'b0;
            pending = 1'b0;
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int k;
        int a_sel;
        int s_sel;
        int waited;
        int ints_before;
        int readies_before;
        seed = 32'hc315;
        rst_n = 1'b0;
        mem_valid = 1'b0;
        mem_addr = '0;
        mem_wstrb = '0;
        mem_wdata = '0;
        int_cmd = 1'b0;
        pending = 1'b0;
        exp_rdata = '0;
        timed_out = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst_n = 1'b1;
        // quiet ports with no activity
        for (k = 0; k < 20; k++) begin
            @(posedge clk);
            if (l15_val !== 1'b0 || mem_ready !== 1'b0 || pico_int !== 1'b0
                || l15_req_ack !== 1'b0) begin
                stim_errs++;
                $display("Mismatch idle: l15_val %h mem_ready %h pico_int %h l15_req_ack %h",
                         l15_val, mem_ready, pico_int, l15_req_ack);
            end
        end
        #1;
        // full-word stores to every pool word and their read back
        for (k = 0; k < 8 && !timed_out; k++) begin
            core_access(pool_addr(k), 4'b1111, $random(seed));
        end
        for (k = 0; k < 8 && !timed_out; k++) begin
            core_access(pool_addr(k), 4'b0000, '0);
        end
        // random mix of partial stores and loads
        for (k = 0; k < 200 && !timed_out; k++) begin
            a_sel = $unsigned($random(seed)) % 8;
            s_sel = $unsigned($random(seed)) % 8;
            core_access(pool_addr(a_sel), pick_strobe(s_sel), $random(seed));
        end
        if (!timed_out) begin
            // interrupt return with the core idle
            ints_before = int_pulses;
            readies_before = ready_pulses;
            int_cmd = 1'b1;
            @(posedge clk);
            #1;
            int_cmd = 1'b0;
            waited = 0;
            while (int_pulses == ints_before && waited < 50) begin
                waited++;
                @(posedge clk);
                #1;
            end
            if (int_pulses == ints_before) begin
                stim_errs++;
                $display("ERROR: interrupt return gave no pico_int pulse within 50 cycles");
            end else begin
                repeat (5) @(posedge clk);
                #1;
                if (int_pulses != ints_before + 1) begin
                    stim_errs++;
                    $display("Mismatch pico_int cycles: got %h expected %h",
                             int_pulses - ints_before, 1);
                end
                if (ready_pulses != readies_before) begin
                    stim_errs++;
                    $display("Mismatch mem_ready pulses on interrupt: got %h expected %h",
                             ready_pulses - readies_before, 0);
                end
                // one accepted request per core access
                if (accepts != accesses) begin
                    stim_errs++;
                    $display("Mismatch accepted requests: got %h expected %h",
                             accepts, accesses);
                end
            end
        end
        finish_run();
    end

endmodule

//--- all.f
hdl/pico_l15_pkg.sv
hdl/pico_decoder.sv
hdl/l15_picoencoder.sv
hdl/pico_l15_transducer.sv
tb/l15_model.sv
tb/tb_pico_l15_transducer.sv

//--- Makefile
TOP := tb_pico_l15_transducer

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f all.f --top-module pico_l15_transducer
	verilator --lint-only --timing -f all.f --top-module $(TOP)

sim:
	verilator --binary --timing -j 0 -f all.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log
